/* src/exec_types_pkg.sv */
`default_nettype none

package exec_types_pkg;

    localparam int WORD_W    = 32;
    localparam int PREG_W    = 6;
    localparam int ROB_ID_W  = 5;
    localparam int NUM_PREGS = 64;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [PREG_W-1:0]   preg_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // both operand words of one lane
    typedef struct packed {
        word_t rs0_data;
        word_t rs1_data;
    } prf_read_t;

    typedef struct packed {
        logic  wen;
        preg_t rd;
        word_t wdata;
    } prf_write_t; // writeback and bypass

    typedef struct packed {
        logic    valid;
        rob_id_t id;
        logic    overflow; // exception flag
    } rob_finish_t;

endpackage

`default_nettype wire

/* src/uop_defs_pkg.sv */
`default_nettype none

package uop_defs_pkg;

    import exec_types_pkg::*;

    localparam int UOP_W       = 6;
    localparam int ALU_CLASS_W = 3;

    // nop first so an all-zero bundle is harmless
    typedef enum logic [UOP_W-1:0] {
        NOP_U,
        OR_U, ORI_U, LUI_U, AND_U, ANDI_U, NOR_U, XOR_U, XORI_U,
        SLL_U, SLLV_U, SRL_U, SRLV_U, SRA_U, SRAV_U,
        ADD_U, ADDI_U, ADDU_U, SUB_U, SUBU_U,
        SLT_U, SLTI_U, SLTU_U, SLTIU_U,
        MFHI_U, MTHI_U,     // hi/lo are renamed so these are plain moves
        CLZ_U, CLO_U,
        BEQ_U, BNE_U, BGEZ_U, BGTZ_U, BLEZ_U, BLTZ_U,
        J_U, JAL_U, JR_U, JALR_U
    } uop_e;

    typedef enum logic [ALU_CLASS_W-1:0] {
        ALU_LOGIC,
        ALU_SHIFT,
        ALU_ARITH,
        ALU_MOVE,
        ALU_COUNT,
        ALU_BRANCH
    } alu_class_e;

    typedef struct packed {
        logic       valid;
        uop_e       uop;
        alu_class_e alu_class;
        rob_id_t    id;
        logic       op0_re;
        logic       op1_re;
        preg_t      op0_preg;
        preg_t      op1_preg;
        logic       dst_we;
        preg_t      dst_preg;
        word_t      imm;
        word_t      branch_addr;  // predicted target in, resolved target out
        logic       branch_taken;
    } uop_bundle_t;

endpackage

`default_nettype wire

/* tests/exec_model_pkg.sv */
`default_nettype none

package exec_model_pkg;

    import exec_types_pkg::*;
    import uop_defs_pkg::*;

    typedef struct packed {
        prf_write_t  wb;
        rob_finish_t finish;
        uop_bundle_t resolved;
    } lane_expect_t;

    word_t shadow_regs [NUM_PREGS]; // architectural view in issue order

    function automatic void clear_shadow();
        for (int i = 0; i < NUM_PREGS; i++) begin
            shadow_regs[i] = '0;
        end
    endfunction

    function automatic alu_class_e class_of(uop_e op);
        case (op)
            OR_U, ORI_U, LUI_U, AND_U, ANDI_U, NOR_U, XOR_U, XORI_U: return ALU_LOGIC;
            SLL_U, SLLV_U, SRL_U, SRLV_U, SRA_U, SRAV_U:             return ALU_SHIFT;
            ADD_U, ADDI_U, ADDU_U, SUB_U, SUBU_U,
            SLT_U, SLTI_U, SLTU_U, SLTIU_U:                          return ALU_ARITH;
            MFHI_U, MTHI_U:                                          return ALU_MOVE;
            CLZ_U, CLO_U:                                            return ALU_COUNT;
            default:                                                 return ALU_BRANCH;
        endcase
    endfunction

    // scan down from the msb
    function automatic word_t leading_zeros(word_t v);
        int unsigned n;
        n = 0;
        while (n < 32 && !v[31 - n]) begin
            n++;
        end
        return word_t'(n);
    endfunction

    function automatic lane_expect_t predict(uop_bundle_t u);
        word_t        a;
        word_t        b;
        word_t        res;
        logic [32:0]  wide;
        logic         ovf;
        logic         taken;
        logic         live;
        lane_expect_t e;
        a     = shadow_regs[u.op0_preg];
        b     = u.op1_re ? shadow_regs[u.op1_preg] : u.imm;
        res   = '0;
        ovf   = 1'b0;
        taken = 1'b0;
        case (u.uop)
            OR_U, ORI_U:   res = a | b;
            LUI_U:         res = u.imm | a;
            AND_U, ANDI_U: res = a & b;
            NOR_U:         res = ~(a | b);
            XOR_U, XORI_U: res = a ^ b;
            SLL_U, SLLV_U: res = b << a[4:0];
            SRL_U, SRLV_U: res = b >> a[4:0];
            SRA_U, SRAV_U: res = word_t'($signed(b) >>> a[4:0]);
            ADD_U, ADDI_U, ADDU_U: begin
                wide = {a[31], a} + {b[31], b};
                res  = wide[31:0];
                ovf  = (u.uop != ADDU_U) && (wide[32] != wide[31]); // addu never traps
            end
            SUB_U, SUBU_U: begin
                wide = {a[31], a} - {b[31], b};
                res  = wide[31:0];
                ovf  = (u.uop == SUB_U) && (wide[32] != wide[31]);
            end
            SLT_U, SLTI_U:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU_U, SLTIU_U: res = (a < b) ? 32'd1 : 32'd0;
            MFHI_U, MTHI_U:  res = a;
            CLZ_U:           res = leading_zeros(a);
            CLO_U:           res = leading_zeros(~a);
            BEQ_U:           taken = (a == b);
            BNE_U:           taken = (a != b);
            BGEZ_U:          taken = ($signed(a) >= 0);
            BGTZ_U:          taken = ($signed(a) > 0);
            BLEZ_U:          taken = ($signed(a) <= 0);
            BLTZ_U:          taken = ($signed(a) < 0);
            J_U, JAL_U, JR_U, JALR_U: taken = 1'b1;
            default: ;
        endcase
        live = u.valid && (u.uop != NOP_U);
        e.wb.wen                = live && u.dst_we && !ovf;
        e.wb.rd                 = u.dst_preg;
        e.wb.wdata              = res;
        e.finish.valid          = live;
        e.finish.id             = u.id;
        e.finish.overflow       = live && ovf;
        e.resolved              = u;
        e.resolved.branch_taken = taken;
        e.resolved.branch_addr  = (u.uop == JR_U || u.uop == JALR_U) ? a : u.branch_addr;
        return e;
    endfunction

    function automatic void commit_write(prf_write_t w);
        if (w.wen) begin
            shadow_regs[w.rd] = w.wdata;
        end
    endfunction

endpackage

`default_nettype wire

/* src/phys_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  logic                       clk,
    input  logic                       rst_n,
    input  exec_types_pkg::preg_t      raddr0,
    input  exec_types_pkg::preg_t      raddr1,
    input  exec_types_pkg::preg_t      raddr2,
    input  exec_types_pkg::preg_t      raddr3,
    output exec_types_pkg::word_t      rdata0,
    output exec_types_pkg::word_t      rdata1,
    output exec_types_pkg::word_t      rdata2,
    output exec_types_pkg::word_t      rdata3,
    input  exec_types_pkg::prf_write_t wr0,
    input  exec_types_pkg::prf_write_t wr1
);
    import exec_types_pkg::*;

    word_t regs [NUM_PREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0.wen) begin
                regs[wr0.rd] <= wr0.wdata;
            end
            if (wr1.wen) begin
                regs[wr1.rd] <= wr1.wdata; // lane 1 wins on a clash
            end
        end
    end

    // write-through uses the same priority as the array write
    function automatic word_t read_port(preg_t addr);
        word_t data;
        data = regs[addr];
        if (wr0.wen && wr0.rd == addr) begin
            data = wr0.wdata;
        end
        if (wr1.wen && wr1.rd == addr) begin
            data = wr1.wdata;
        end
        return data;
    endfunction

    always_comb begin
        rdata0 = read_port(raddr0);
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
        rdata3 = read_port(raddr3);
    end

endmodule

`default_nettype wire

/* src/operand_read.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_read (
    input  logic                        clk,
    input  logic                        rst_n,
    input  uop_defs_pkg::uop_bundle_t   issue,
    input  exec_types_pkg::prf_read_t   rdata,
    output uop_defs_pkg::uop_bundle_t   uop_q,
    output exec_types_pkg::prf_read_t   rdata_q
);
    import uop_defs_pkg::*;

    uop_bundle_t payload_q;
    logic        valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= issue;
        rdata_q   <= rdata; // read in the issue cycle
    end

    always_comb begin
        uop_q       = payload_q;
        uop_q.valid = valid_q;
    end

endmodule

`default_nettype wire

/* src/lead_count.sv */
`timescale 1ns/1ps
`default_nettype none

module lead_count (
    input  exec_types_pkg::word_t value,
    input  logic                  count_ones,
    output exec_types_pkg::word_t count
);
    import exec_types_pkg::*;

    word_t v;

    assign v = count_ones ? ~value : value; // clo is clz of the inverse

    // highest set bit wins and 32 means none is set
    always_comb begin
        count = word_t'(WORD_W);
        for (int i = 0; i < WORD_W; i++) begin
            if (v[i]) begin
                count = word_t'(WORD_W - 1 - i);
            end
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  uop_defs_pkg::uop_bundle_t    uop,
    input  exec_types_pkg::prf_read_t    rdata,
    input  exec_types_pkg::prf_write_t   bypass0,
    input  exec_types_pkg::prf_write_t   bypass1,
    output exec_types_pkg::prf_write_t   wb,
    output exec_types_pkg::rob_finish_t  finish,
    output uop_defs_pkg::uop_bundle_t    uop_out
);
    import exec_types_pkg::*;
    import uop_defs_pkg::*;

    uop_e       op;
    word_t      src0;
    word_t      src1;
    logic [4:0] shamt;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    word_t      count_res;
    word_t      result;
    word_t      add_b;
    word_t      sum;
    logic       is_sub;
    logic       lt;
    logic       overflow;
    logic       taken;
    word_t      target;
    logic       fin_valid;

    assign op = uop.uop;

    // lane 0 bypass checked before lane 1
    always_comb begin
        src0 = rdata.rs0_data;
        if (uop.op0_re) begin
            if (bypass0.wen && bypass0.rd == uop.op0_preg) begin
                src0 = bypass0.wdata;
            end else if (bypass1.wen && bypass1.rd == uop.op0_preg) begin
                src0 = bypass1.wdata;
            end
        end
    end

    always_comb begin
        src1 = uop.imm; // immediate form
        if (uop.op1_re) begin
            if (bypass0.wen && bypass0.rd == uop.op1_preg) begin
                src1 = bypass0.wdata;
            end else if (bypass1.wen && bypass1.rd == uop.op1_preg) begin
                src1 = bypass1.wdata;
            end else begin
                src1 = rdata.rs1_data;
            end
        end
    end

    always_comb begin
        unique case (op)
            OR_U, ORI_U:   logic_res = src0 | src1;
            LUI_U:         logic_res = uop.imm | src0;
            AND_U, ANDI_U: logic_res = src0 & src1;
            NOR_U:         logic_res = ~(src0 | src1);
            XOR_U, XORI_U: logic_res = src0 ^ src1;
            default:       logic_res = '0;
        endcase
    end

    assign shamt = src0[4:0];

    always_comb begin
        unique case (op)
            SLL_U, SLLV_U: shift_res = src1 << shamt;
            SRL_U, SRLV_U: shift_res = src1 >> shamt;
            SRA_U, SRAV_U: shift_res = word_t'($signed(src1) >>> shamt);
            default:       shift_res = '0;
        endcase
    end

    // subtract as a + ~b + 1
    assign is_sub = op inside {SUB_U, SUBU_U};
    assign add_b  = is_sub ? ~src1 : src1;
    assign sum    = src0 + add_b + word_t'(is_sub);
    assign overflow = (op inside {ADD_U, ADDI_U, SUB_U}) &&
                      (src0[31] == add_b[31]) && (sum[31] != src0[31]);

    assign lt = (op inside {SLT_U, SLTI_U}) ? ($signed(src0) < $signed(src1)) : (src0 < src1);
    assign arith_res = (op inside {SLT_U, SLTI_U, SLTU_U, SLTIU_U}) ? word_t'(lt) : sum;

    lead_count u_lead_count (
        .value      (src0),
        .count_ones (op == CLO_U),
        .count      (count_res)
    );

    always_comb begin
        unique case (op)
            BEQ_U:                    taken = (src0 == src1);
            BNE_U:                    taken = (src0 != src1);
            BGEZ_U:                   taken = ~src0[31];
            BGTZ_U:                   taken = ~src0[31] & (|src0[30:0]);
            BLEZ_U:                   taken = src0[31] | ~(|src0[30:0]);
            BLTZ_U:                   taken = src0[31];
            J_U, JAL_U, JR_U, JALR_U: taken = 1'b1;
            default:                  taken = 1'b0;
        endcase
    end

    assign target = (op inside {JR_U, JALR_U}) ? src0 : uop.branch_addr;

    always_comb begin
        unique case (uop.alu_class)
            ALU_LOGIC: result = logic_res;
            ALU_SHIFT: result = shift_res;
            ALU_ARITH: result = arith_res;
            ALU_MOVE:  result = src0;
            ALU_COUNT: result = count_res;
            default:   result = '0; // branch
        endcase
    end

    assign fin_valid = uop.valid && (op != NOP_U);

    always_comb begin
        wb.wen          = fin_valid && uop.dst_we && !overflow; // no write on overflow trap
        wb.rd           = uop.dst_preg;
        wb.wdata        = result;
        finish.valid    = fin_valid;
        finish.id       = uop.id;
        finish.overflow = fin_valid && overflow;
        uop_out              = uop;
        uop_out.branch_taken = taken;
        uop_out.branch_addr  = target;
    end

endmodule

`default_nettype wire

/* src/writeback_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  exec_types_pkg::prf_write_t   wb_d,
    input  exec_types_pkg::rob_finish_t  finish_d,
    input  uop_defs_pkg::uop_bundle_t    resolved_d,
    output exec_types_pkg::prf_write_t   wb,
    output exec_types_pkg::rob_finish_t  finish,
    output uop_defs_pkg::uop_bundle_t    resolved
);
    import exec_types_pkg::*;
    import uop_defs_pkg::*;

    prf_write_t  wb_q;
    rob_finish_t finish_q;
    uop_bundle_t resolved_q;
    logic        wen_q;
    logic        fin_valid_q;
    logic        fin_ovf_q;
    logic        res_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wen_q       <= 1'b0;
            fin_valid_q <= 1'b0;
            fin_ovf_q   <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            wen_q       <= wb_d.wen;
            fin_valid_q <= finish_d.valid;
            fin_ovf_q   <= finish_d.overflow;
            res_valid_q <= resolved_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_q       <= wb_d;
        finish_q   <= finish_d;
        resolved_q <= resolved_d;
    end

    // same word feeds the regfile, both bypass inputs and the port
    always_comb begin
        wb              = wb_q;
        wb.wen          = wen_q;
        finish          = finish_q;
        finish.valid    = fin_valid_q;
        finish.overflow = fin_ovf_q;
        resolved        = resolved_q;
        resolved.valid  = res_valid_q;
    end

endmodule

`default_nettype wire

/* src/exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
    input  logic                         clk,
    input  logic                         rst_n,
    input  uop_defs_pkg::uop_bundle_t    issue0,
    input  uop_defs_pkg::uop_bundle_t    issue1,
    output exec_types_pkg::prf_write_t   wb0,
    output exec_types_pkg::prf_write_t   wb1,
    output exec_types_pkg::rob_finish_t  finish0,
    output exec_types_pkg::rob_finish_t  finish1,
    output uop_defs_pkg::uop_bundle_t    resolved0,
    output uop_defs_pkg::uop_bundle_t    resolved1
);
    import exec_types_pkg::*;
    import uop_defs_pkg::*;

    prf_read_t   rf_read0;  // issue-cycle reads
    prf_read_t   rf_read1;
    uop_bundle_t uop_q0;
    uop_bundle_t uop_q1;
    prf_read_t   rdata_q0;
    prf_read_t   rdata_q1;
    prf_write_t  wb_d0;
    prf_write_t  wb_d1;
    rob_finish_t finish_d0;
    rob_finish_t finish_d1;
    uop_bundle_t resolved_d0;
    uop_bundle_t resolved_d1;

    phys_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr0 (issue0.op0_preg),
        .raddr1 (issue0.op1_preg),
        .raddr2 (issue1.op0_preg),
        .raddr3 (issue1.op1_preg),
        .rdata0 (rf_read0.rs0_data),
        .rdata1 (rf_read0.rs1_data),
        .rdata2 (rf_read1.rs0_data),
        .rdata3 (rf_read1.rs1_data),
        .wr0    (wb0),
        .wr1    (wb1)
    );

    operand_read u_read0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue0),
        .rdata   (rf_read0),
        .uop_q   (uop_q0),
        .rdata_q (rdata_q0)
    );

    operand_read u_read1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue1),
        .rdata   (rf_read1),
        .uop_q   (uop_q1),
        .rdata_q (rdata_q1)
    );

    // both ALUs see both lanes' registered results
    alu u_alu0 (
        .uop     (uop_q0),
        .rdata   (rdata_q0),
        .bypass0 (wb0),
        .bypass1 (wb1),
        .wb      (wb_d0),
        .finish  (finish_d0),
        .uop_out (resolved_d0)
    );

    alu u_alu1 (
        .uop     (uop_q1),
        .rdata   (rdata_q1),
        .bypass0 (wb0),
        .bypass1 (wb1),
        .wb      (wb_d1),
        .finish  (finish_d1),
        .uop_out (resolved_d1)
    );

    writeback_reg u_wb0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_d       (wb_d0),
        .finish_d   (finish_d0),
        .resolved_d (resolved_d0),
        .wb         (wb0),
        .finish     (finish0),
        .resolved   (resolved0)
    );

    writeback_reg u_wb1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_d       (wb_d1),
        .finish_d   (finish_d1),
        .resolved_d (resolved_d1),
        .wb         (wb1),
        .finish     (finish1),
        .resolved   (resolved1)
    );

endmodule

`default_nettype wire

/* tests/tb_exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;
    import exec_types_pkg::*;
    import uop_defs_pkg::*;
    import exec_model_pkg::*;

    localparam int unsigned SEED           = 29899;
    localparam int          RESET_CYCLES   = 4;
    localparam int          RANDOM_CYCLES  = 400;
    localparam int          READBACK       = NUM_PREGS / 2;
    localparam int          DRAIN          = 2;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + RANDOM_CYCLES + READBACK + DRAIN + 20;

    logic        clk;
    logic        rst_n;
    uop_bundle_t issue0;
    uop_bundle_t issue1;
    prf_write_t  wb0;
    prf_write_t  wb1;
    rob_finish_t finish0;
    rob_finish_t finish1;
    uop_bundle_t resolved0;
    uop_bundle_t resolved1;

    lane_expect_t exp0_q [$]; // one entry per issue cycle
    lane_expect_t exp1_q [$];
    int           cycle_count = 0;

    exec_cluster u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue0    (issue0),
        .issue1    (issue1),
        .wb0       (wb0),
        .wb1       (wb1),
        .finish0   (finish0),
        .finish1   (finish1),
        .resolved0 (resolved0),
        .resolved1 (resolved1)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_value(string name, logic [127:0] expected, logic [127:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_lane(int lane, lane_expect_t e, prf_write_t wb, rob_finish_t fin,
                              uop_bundle_t res);
        string tag;
        uop_e  op;
        op  = e.resolved.uop;
        tag = $sformatf("lane%0d %s", lane, op.name());
        compare_value({tag, " wen"}, 128'(e.wb.wen), 128'(wb.wen));
        if (e.wb.wen) begin
            compare_value({tag, " rd"}, 128'(e.wb.rd), 128'(wb.rd));
            compare_value({tag, " wdata"}, 128'(e.wb.wdata), 128'(wb.wdata));
        end
        compare_value({tag, " finish valid"}, 128'(e.finish.valid), 128'(fin.valid));
        if (e.finish.valid) begin
            compare_value({tag, " finish"}, 128'(e.finish), 128'(fin));
        end
        compare_value({tag, " resolved valid"}, 128'(e.resolved.valid), 128'(res.valid));
        if (e.resolved.valid) begin
            compare_value({tag, " resolved"}, 128'(e.resolved), 128'(res));
        end
    endtask

    // small range half the time so dependencies are frequent
    function automatic preg_t pick_preg();
        if ($urandom_range(0, 1) == 0) begin
            return preg_t'($urandom_range(0, 7));
        end
        return preg_t'($urandom_range(0, NUM_PREGS - 1));
    endfunction

    function automatic uop_bundle_t random_uop();
        uop_bundle_t u;
        uop_e        op;
        op             = uop_e'(6'($urandom_range(0, int'(JALR_U))));
        u              = '0;
        u.valid        = ($urandom_range(0, 9) < 8);
        u.uop          = op;
        u.alu_class    = class_of(op);
        u.id           = rob_id_t'($urandom);
        u.op0_re       = 1'b1;
        u.op1_re       = 1'($urandom_range(0, 1));
        u.op0_preg     = pick_preg();
        u.op1_preg     = pick_preg();
        u.dst_we       = (class_of(op) != ALU_BRANCH);
        u.dst_preg     = pick_preg();
        u.imm          = $urandom;
        u.branch_addr  = $urandom;
        u.branch_taken = 1'($urandom_range(0, 1));
        return u;
    endfunction

    // move a register onto itself to read it back
    function automatic uop_bundle_t readback_uop(preg_t r);
        uop_bundle_t u;
        u           = '0;
        u.valid     = 1'b1;
        u.uop       = MFHI_U;
        u.alu_class = ALU_MOVE;
        u.id        = rob_id_t'(r);
        u.op0_re    = 1'b1;
        u.op0_preg  = r;
        u.dst_we    = 1'b1;
        u.dst_preg  = r;
        return u;
    endfunction

    task automatic issue_cycle(uop_bundle_t b0, uop_bundle_t b1);
        lane_expect_t e0;
        lane_expect_t e1;
        @(posedge clk);
        issue0 <= b0;
        issue1 <= b1;
        e0 = predict(b0); // both lanes see the state before this cycle
        e1 = predict(b1);
        commit_write(e0.wb);
        commit_write(e1.wb);
        exp0_q.push_back(e0);
        exp1_q.push_back(e1);
        @(negedge clk);
        if (exp0_q.size() > 2) begin
            check_lane(0, exp0_q.pop_front(), wb0, finish0, resolved0);
            check_lane(1, exp1_q.pop_front(), wb1, finish1, resolved1);
        end
    endtask

    initial begin
        uop_bundle_t b0;
        uop_bundle_t b1;
        void'($urandom(SEED));
        clk    = 1'b0;
        rst_n  = 1'b0;
        issue0 = '0;
        issue1 = '0;
        clear_shadow();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_value("reset valid outputs", 128'(0),
                      128'({wb0.wen, wb1.wen, finish0.valid, finish1.valid,
                            resolved0.valid, resolved1.valid}));
        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            b0 = random_uop();
            b1 = random_uop();
            if (b1.dst_preg == b0.dst_preg) begin
                b1.dst_preg = b0.dst_preg + preg_t'(1);
            end
            issue_cycle(b0, b1);
        end
        for (int r = 0; r < NUM_PREGS; r += 2) begin
            issue_cycle(readback_uop(preg_t'(r)), readback_uop(preg_t'(r + 1)));
        end
        repeat (DRAIN) issue_cycle('0, '0); // flush the last checks
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/exec_types_pkg.sv
src/uop_defs_pkg.sv
tests/exec_model_pkg.sv
src/phys_regfile.sv
src/operand_read.sv
src/lead_count.sv
src/alu.sv
src/writeback_reg.sv
src/exec_cluster.sv
tests/tb_exec_cluster.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
RTL_TOP   ?= exec_cluster
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
